/* include/mips_macros.svh */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// First fetch address after reset, in the boot ROM segment
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// A jump here stops the core
`define MIPS_HALT_ADDR 32'h0000_0000

// Return address register for JAL
`define MIPS_LINK_REG 5'd31

// Result register, mirrored on register_v0
`define MIPS_V0_REG 5'd2

`endif

/* src/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

	typedef logic [31:0] word_t; // Data or address word
	typedef logic [4:0] reg_idx_t; // GPR number

	// Primary opcodes, bits 31:26
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00, // SPECIAL, decoded by funct
		OP_J     = 6'h02,
		OP_JAL   = 6'h03,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDIU = 6'h09,
		OP_SLTI  = 6'h0A,
		OP_SLTIU = 6'h0B,
		OP_ANDI  = 6'h0C,
		OP_ORI   = 6'h0D,
		OP_XORI  = 6'h0E,
		OP_LUI   = 6'h0F,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2B
	} opcode_t;

	// SPECIAL function codes, bits 5:0
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_SRA  = 6'h03,
		FN_JR   = 6'h08,
		FN_JALR = 6'h09,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLT  = 6'h2A,
		FN_SLTU = 6'h2B
	} funct_t;

	// All fields of one instruction, side by side
	typedef struct packed {
		opcode_t opcode;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		logic [4:0] shamt;
		funct_t funct;
		logic [15:0] imm; // I-type immediate
		logic [25:0] target; // J-type word index
	} instr_fields_t;

endpackage

`default_nettype wire

/* src/mips_ctrl_pkg.sv */
`default_nettype none

package mips_ctrl_pkg;

	// ALU function select
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0, // Also address calculation
		ALU_SUB  = 4'd1, // Also branch compare
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLT  = 4'd5,
		ALU_SLTU = 4'd6,
		ALU_SLL  = 4'd7,
		ALU_SRL  = 4'd8,
		ALU_SRA  = 4'd9,
		ALU_LUI  = 4'd10
	} alu_op_t;

	// Register write-back source
	typedef enum logic [1:0] {
		WB_ALU  = 2'd0,
		WB_MEM  = 2'd1,
		WB_LINK = 2'd2 // Return address
	} wb_src_t;

	// Destination register field
	typedef enum logic [1:0] {
		DEST_RT   = 2'd0, // I-type
		DEST_RD   = 2'd1, // R-type
		DEST_LINK = 2'd2 // JAL, fixed $ra
	} dest_sel_t;

	typedef struct packed {
		logic reg_write;
		dest_sel_t dest_sel;
		logic alu_src_imm; // B operand from immediate
		logic imm_zero_ext; // Logical immediates
		logic shift_by_shamt; // Amount from instruction, not rs
		alu_op_t alu_op;
		wb_src_t wb_src;
		logic mem_read;
		logic mem_write;
		logic branch_eq;
		logic branch_ne;
		logic jump_imm; // J, JAL
		logic jump_reg; // JR, JALR
	} ctrl_t;

endpackage

`default_nettype wire

/* src/mips_alu.sv */
`default_nettype none

module mips_alu (
	input mips_ctrl_pkg::alu_op_t op,
	input mips_isa_pkg::word_t a,
	input mips_isa_pkg::word_t b,
	input logic [4:0] shamt,
	output mips_isa_pkg::word_t result,
	output logic zero
);
	import mips_isa_pkg::*;
	import mips_ctrl_pkg::*;

	word_t sum;
	word_t diff;
	logic lt_signed;
	logic lt_unsigned;

	assign sum = a + b; // Wraps, no overflow trap
	assign diff = a - b;
	assign lt_signed = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (op)
			ALU_ADD: result = sum;
			ALU_SUB: result = diff;
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_SLT: result = {31'b0, lt_signed};
			ALU_SLTU: result = {31'b0, lt_unsigned};
			ALU_SLL: result = b << shamt; // Shifts act on rt
			ALU_SRL: result = b >> shamt;
			ALU_SRA: result = $signed(b) >>> shamt; // Sign fill
			ALU_LUI: result = {b[15:0], 16'b0};
			default: result = '0;
		endcase
	end

	assign zero = (result == '0); // Branches run ALU_SUB

endmodule

`default_nettype wire

/* src/mips_regfile.sv */
`default_nettype none

`include "mips_macros.svh"

module mips_regfile (
	input logic clk,
	input logic reset,
	input logic write_en,
	input mips_isa_pkg::reg_idx_t read_a,
	input mips_isa_pkg::reg_idx_t read_b,
	input mips_isa_pkg::reg_idx_t write_addr,
	input mips_isa_pkg::word_t write_data,
	output mips_isa_pkg::word_t data_a,
	output mips_isa_pkg::word_t data_b,
	output mips_isa_pkg::word_t v0
);
	import mips_isa_pkg::*;

	word_t regs [1:31]; // $zero has no storage

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en && (write_addr != '0)) begin // Writes to $zero dropped
			regs[write_addr] <= write_data;
		end
	end

	// Combinational reads, $zero reads as 0
	assign data_a = (read_a == '0) ? '0 : regs[read_a];
	assign data_b = (read_b == '0) ? '0 : regs[read_b];
	assign v0 = regs[`MIPS_V0_REG]; // Observation tap

endmodule

`default_nettype wire

/* src/mips_decoder.sv */
`default_nettype none

module mips_decoder (
	input mips_isa_pkg::instr_fields_t fields,
	output mips_ctrl_pkg::ctrl_t ctrl,
	output logic illegal
);
	import mips_isa_pkg::*;
	import mips_ctrl_pkg::*;

	always_comb begin
		ctrl = '0; // No write, no memory, no jump
		illegal = 1'b0;
		case (fields.opcode)
			OP_RTYPE: begin
				ctrl.reg_write = 1'b1;
				ctrl.dest_sel = DEST_RD;
				case (fields.funct)
					FN_ADDU: ctrl.alu_op = ALU_ADD;
					FN_SUBU: ctrl.alu_op = ALU_SUB;
					FN_AND: ctrl.alu_op = ALU_AND;
					FN_OR: ctrl.alu_op = ALU_OR;
					FN_XOR: ctrl.alu_op = ALU_XOR;
					FN_SLT: ctrl.alu_op = ALU_SLT;
					FN_SLTU: ctrl.alu_op = ALU_SLTU;
					FN_SLL, FN_SRL, FN_SRA: begin
						ctrl.shift_by_shamt = 1'b1; // Constant shifts only
						ctrl.alu_op = (fields.funct == FN_SLL) ? ALU_SLL :
							(fields.funct == FN_SRL) ? ALU_SRL : ALU_SRA;
					end
					FN_JR: begin
						ctrl.reg_write = 1'b0;
						ctrl.jump_reg = 1'b1;
					end
					FN_JALR: begin
						ctrl.jump_reg = 1'b1;
						ctrl.wb_src = WB_LINK; // Link into rd
					end
					default: begin
						ctrl = '0;
						illegal = 1'b1;
					end
				endcase
			end
			OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				ctrl.reg_write = 1'b1;
				ctrl.dest_sel = DEST_RT;
				ctrl.alu_src_imm = 1'b1;
				case (fields.opcode)
					OP_SLTI: ctrl.alu_op = ALU_SLT;
					OP_SLTIU: ctrl.alu_op = ALU_SLTU; // Sign-extended, compared unsigned
					OP_LUI: ctrl.alu_op = ALU_LUI;
					OP_ANDI: begin
						ctrl.alu_op = ALU_AND;
						ctrl.imm_zero_ext = 1'b1;
					end
					OP_ORI: begin
						ctrl.alu_op = ALU_OR;
						ctrl.imm_zero_ext = 1'b1;
					end
					OP_XORI: begin
						ctrl.alu_op = ALU_XOR;
						ctrl.imm_zero_ext = 1'b1;
					end
					default: ctrl.alu_op = ALU_ADD; // ADDIU
				endcase
			end
			OP_LW: begin
				ctrl.reg_write = 1'b1;
				ctrl.dest_sel = DEST_RT;
				ctrl.alu_src_imm = 1'b1; // Base plus offset
				ctrl.wb_src = WB_MEM;
				ctrl.mem_read = 1'b1;
			end
			OP_SW: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				ctrl.alu_op = ALU_SUB; // Zero flag gives rs == rt
				ctrl.branch_eq = (fields.opcode == OP_BEQ);
				ctrl.branch_ne = (fields.opcode == OP_BNE);
			end
			OP_J: ctrl.jump_imm = 1'b1;
			OP_JAL: begin
				ctrl.jump_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.dest_sel = DEST_LINK;
				ctrl.wb_src = WB_LINK;
			end
			default: illegal = 1'b1; // Unsupported opcode, no effect
		endcase
	end

endmodule

`default_nettype wire

/* src/mips_pc_unit.sv */
`default_nettype none

`include "mips_macros.svh"

module mips_pc_unit (
	input logic clk,
	input logic reset,
	input logic clk_enable,
	input mips_ctrl_pkg::ctrl_t ctrl,
	input mips_isa_pkg::instr_fields_t fields,
	input logic zero,
	input mips_isa_pkg::word_t rs_value,
	output mips_isa_pkg::word_t pc,
	output mips_isa_pkg::word_t pc_plus4,
	output logic active
);
	import mips_isa_pkg::*;

	word_t branch_offset;
	word_t branch_target;
	word_t jump_target;
	word_t next_pc;
	logic branch_taken;

	assign pc_plus4 = pc + 32'd4; // Also the link value, no delay slot
	assign branch_offset = {{14{fields.imm[15]}}, fields.imm, 2'b00}; // Word offset to bytes
	assign branch_target = pc_plus4 + branch_offset;
	assign jump_target = {pc_plus4[31:28], fields.target, 2'b00}; // Same 256 MB region

	// Equal compare comes from ALU subtraction
	assign branch_taken = (ctrl.branch_eq & zero) | (ctrl.branch_ne & ~zero);

	always_comb begin
		if (ctrl.jump_reg) begin
			next_pc = rs_value;
		end else if (ctrl.jump_imm) begin
			next_pc = jump_target;
		end else if (branch_taken) begin
			next_pc = branch_target;
		end else begin
			next_pc = pc_plus4;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= `MIPS_RESET_VECTOR;
			active <= 1'b1;
		end else if (clk_enable && active) begin // Frozen once halted
			pc <= next_pc;
			if (next_pc == `MIPS_HALT_ADDR) begin
				active <= 1'b0; // Jump to zero ends the program
			end
		end
	end

endmodule

`default_nettype wire

/* src/cpu_mips_harvard.sv */
`default_nettype none

`include "mips_macros.svh"

module cpu_mips_harvard (
	input logic clk,
	input logic reset,
	input logic clk_enable,
	output logic active,
	output mips_isa_pkg::word_t register_v0,
	output mips_isa_pkg::word_t instr_address,
	input mips_isa_pkg::word_t instr_readdata,
	output mips_isa_pkg::word_t data_address,
	output logic data_read,
	output logic data_write,
	output mips_isa_pkg::word_t data_writedata,
	input mips_isa_pkg::word_t data_readdata,
	output logic illegal_instr
);
	import mips_isa_pkg::*;
	import mips_ctrl_pkg::*;

	instr_fields_t fields;
	ctrl_t ctrl;
	logic illegal;
	word_t rs_value;
	word_t rt_value;
	word_t imm_ext;
	word_t alu_b;
	word_t alu_result;
	logic alu_zero;
	logic [4:0] shift_amount;
	word_t pc_plus4;
	word_t wb_value;
	reg_idx_t wb_addr;
	logic wb_en;

	// Instruction word into its fields
	assign fields.opcode = opcode_t'(instr_readdata[31:26]);
	assign fields.rs = instr_readdata[25:21];
	assign fields.rt = instr_readdata[20:16];
	assign fields.rd = instr_readdata[15:11];
	assign fields.shamt = instr_readdata[10:6];
	assign fields.funct = funct_t'(instr_readdata[5:0]);
	assign fields.imm = instr_readdata[15:0];
	assign fields.target = instr_readdata[25:0];

	mips_decoder decoder_i (
		.fields(fields),
		.ctrl(ctrl),
		.illegal(illegal)
	);

	mips_pc_unit pc_unit_i (
		.clk(clk),
		.reset(reset),
		.clk_enable(clk_enable),
		.ctrl(ctrl),
		.fields(fields),
		.zero(alu_zero),
		.rs_value(rs_value),
		.pc(instr_address),
		.pc_plus4(pc_plus4),
		.active(active)
	);

	assign wb_en = ctrl.reg_write & active & clk_enable; // Retire only on a live cycle

	mips_regfile regfile_i (
		.clk(clk),
		.reset(reset),
		.write_en(wb_en),
		.read_a(fields.rs),
		.read_b(fields.rt),
		.write_addr(wb_addr),
		.write_data(wb_value),
		.data_a(rs_value),
		.data_b(rt_value),
		.v0(register_v0)
	);

	// Operand B
	assign imm_ext = ctrl.imm_zero_ext ? {16'b0, fields.imm} : {{16{fields.imm[15]}}, fields.imm};
	assign alu_b = ctrl.alu_src_imm ? imm_ext : rt_value;
	assign shift_amount = ctrl.shift_by_shamt ? fields.shamt : rs_value[4:0];

	mips_alu alu_i (
		.op(ctrl.alu_op),
		.a(rs_value),
		.b(alu_b),
		.shamt(shift_amount),
		.result(alu_result),
		.zero(alu_zero)
	);

	// Write-back value and destination
	always_comb begin
		case (ctrl.wb_src)
			WB_MEM: wb_value = data_readdata;
			WB_LINK: wb_value = pc_plus4; // No delay slot, return to next
			default: wb_value = alu_result;
		endcase
		case (ctrl.dest_sel)
			DEST_RD: wb_addr = fields.rd;
			DEST_LINK: wb_addr = `MIPS_LINK_REG;
			default: wb_addr = fields.rt;
		endcase
	end

	// Data port
	assign data_address = alu_result;
	assign data_writedata = rt_value;
	assign data_read = ctrl.mem_read & active;
	assign data_write = ctrl.mem_write & active & clk_enable; // One store per retired SW
	assign illegal_instr = illegal & active; // Debug only

endmodule

`default_nettype wire

/* bench/cpu_mips_harvard_tb.sv */
`default_nettype none

`include "mips_macros.svh"

module cpu_mips_harvard_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import mips_isa_pkg::*;

	localparam int NUM_ROWS = 7;
	localparam int PROG_LEN = 12;
	localparam int TIMEOUT_NS = NUM_ROWS * (PROG_LEN * 4 + 8) * 20; // Stalls, reset, post-halt

	typedef struct packed {
		logic rand_en; // Random clk_enable
		logic illegal; // Unsupported word in the program
		word_t v0; // Expected register_v0
		word_t addr; // Data address to check
		word_t data; // Expected word there
	} test_row_t;

	logic clk;
	logic reset;
	logic clk_enable;
	logic active;
	logic data_read;
	logic data_write;
	logic illegal_instr;
	word_t register_v0;
	word_t instr_address;
	word_t instr_readdata;
	word_t data_address;
	word_t data_writedata;
	word_t data_readdata;
	word_t fetch_offset;
	word_t halt_fetch; // Word seen outside the ROM

	word_t imem [64];
	word_t dmem [64];
	word_t row_prog [NUM_ROWS][PROG_LEN];
	test_row_t rows [NUM_ROWS];
	string row_name [NUM_ROWS];
	int error_count = 0;
	int pass_count = 0;

	cpu_mips_harvard cpu_mips_harvard_i (
		.clk(clk),
		.reset(reset),
		.clk_enable(clk_enable),
		.active(active),
		.register_v0(register_v0),
		.instr_address(instr_address),
		.instr_readdata(instr_readdata),
		.data_address(data_address),
		.data_read(data_read),
		.data_write(data_write),
		.data_writedata(data_writedata),
		.data_readdata(data_readdata),
		.illegal_instr(illegal_instr)
	);

	always #10 clk = ~clk; // 20 ns period

	// Instruction ROM starts at the reset vector, parked word elsewhere
	assign fetch_offset = instr_address - `MIPS_RESET_VECTOR;
	assign instr_readdata = (fetch_offset < 32'd256) ? imem[fetch_offset[7:2]] : halt_fetch;
	assign data_readdata = data_read ? dmem[data_address[7:2]] : '0; // Same-cycle read on strobe

	function automatic word_t fill_word(logic [5:0] idx);
		return {16'hDA7A, 10'h000, idx}; // Unique per word
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 64; i++) begin
				dmem[i] <= fill_word(6'(i));
			end
		end else if (data_write) begin
			dmem[data_address[7:2]] <= data_writedata;
		end
	end

	function automatic word_t rtype_word(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
		logic [4:0] sh, funct_t fn);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t itype_word(opcode_t op, reg_idx_t rs, reg_idx_t rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jtype_word(opcode_t op, word_t dest);
		return {op, dest[27:2]}; // Word index inside the region
	endfunction

	function automatic word_t bool_word(logic cond);
		return cond ? 32'd1 : 32'd0;
	endfunction

	function automatic logic next_enable(logic rand_en);
		return rand_en ? (($urandom % 32'd4) != 32'd0) : 1'b1; // About one stall in four
	endfunction

	task automatic check_word(input string sig, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("[FAIL] t=%0t %s expected %h got %h", $time, sig, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_active(input string sig, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("[FAIL] t=%0t %s expected %b got %b", $time, sig, expected, actual);
			error_count++;
		end
	endtask

	task automatic build_table();
		word_t a;
		word_t b;
		word_t x;
		word_t base;
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int k = 0; k < PROG_LEN; k++) begin
				row_prog[r][k] = '0; // NOP padding
			end
		end
		// Register arithmetic and logic
		a = 32'd100;
		b = 32'hFFFF_FFF9;
		x = ((a + b) ^ (a - b)) | (a & b);
		row_name[0] = "arith";
		row_prog[0][0] = itype_word(OP_ADDIU, 0, 8, 16'd100);
		row_prog[0][1] = itype_word(OP_ADDIU, 0, 9, 16'hFFF9);
		row_prog[0][2] = rtype_word(8, 9, 10, 0, FN_ADDU);
		row_prog[0][3] = rtype_word(8, 9, 11, 0, FN_SUBU);
		row_prog[0][4] = rtype_word(10, 11, 2, 0, FN_XOR);
		row_prog[0][5] = rtype_word(8, 9, 12, 0, FN_AND);
		row_prog[0][6] = rtype_word(2, 12, 13, 0, FN_OR);
		row_prog[0][7] = rtype_word(9, 8, 14, 0, FN_SLT);
		row_prog[0][8] = rtype_word(8, 9, 15, 0, FN_SLTU);
		row_prog[0][9] = rtype_word(14, 15, 14, 0, FN_ADDU);
		row_prog[0][10] = rtype_word(13, 14, 2, 0, FN_ADDU);
		row_prog[0][11] = rtype_word(0, 0, 0, 0, FN_JR);
		rows[0] = '{1'b0, 1'b0, x + bool_word($signed(b) < $signed(a)) + bool_word(a < b),
			32'h20, fill_word(6'd8)};
		// Immediates, zero and sign extension
		a = 32'h8421_0000 | 32'h0000_F0F0;
		b = a ^ 32'h0000_FFFF;
		x = b & 32'h0000_8F00;
		row_name[1] = "immediate";
		row_prog[1][0] = itype_word(OP_LUI, 0, 8, 16'h8421);
		row_prog[1][1] = itype_word(OP_ORI, 8, 8, 16'hF0F0);
		row_prog[1][2] = itype_word(OP_XORI, 8, 9, 16'hFFFF);
		row_prog[1][3] = itype_word(OP_ANDI, 9, 10, 16'h8F00);
		row_prog[1][4] = itype_word(OP_SLTI, 8, 11, 16'hFFFF); // -1
		row_prog[1][5] = itype_word(OP_SLTIU, 10, 12, 16'hFFFE); // -2
		row_prog[1][6] = rtype_word(9, 10, 2, 0, FN_ADDU);
		row_prog[1][7] = rtype_word(2, 11, 2, 0, FN_ADDU);
		row_prog[1][8] = rtype_word(2, 12, 2, 0, FN_ADDU);
		row_prog[1][9] = rtype_word(0, 0, 0, 0, FN_JR);
		rows[1] = '{1'b0, 1'b0, b + x + bool_word($signed(a) < -32'sd1) +
			bool_word(x < 32'hFFFF_FFFE), 32'h24, fill_word(6'd9)};
		// Constant shifts
		a = 32'hFFFF_EDCB;
		row_name[2] = "shift";
		row_prog[2][0] = itype_word(OP_ADDIU, 0, 8, 16'hEDCB);
		row_prog[2][1] = rtype_word(0, 8, 9, 4, FN_SLL);
		row_prog[2][2] = rtype_word(0, 8, 10, 12, FN_SRL);
		row_prog[2][3] = rtype_word(0, 8, 11, 8, FN_SRA);
		row_prog[2][4] = rtype_word(9, 10, 2, 0, FN_XOR);
		row_prog[2][5] = rtype_word(2, 11, 2, 0, FN_ADDU);
		row_prog[2][6] = rtype_word(0, 0, 0, 0, FN_JR);
		rows[2] = '{1'b0, 1'b0, ((a << 4) ^ (a >> 12)) + word_t'($signed(a) >>> 8),
			32'h28, fill_word(6'd10)};
		// Store then load, $zero write ignored
		row_name[3] = "memory";
		row_prog[3][0] = itype_word(OP_ADDIU, 0, 8, 16'h0040); // Base
		row_prog[3][1] = itype_word(OP_ADDIU, 0, 9, 16'h1357);
		row_prog[3][2] = itype_word(OP_LUI, 0, 10, 16'h2468);
		row_prog[3][3] = rtype_word(9, 10, 9, 0, FN_OR);
		row_prog[3][4] = itype_word(OP_SW, 8, 9, 16'h0008);
		row_prog[3][5] = itype_word(OP_ADDIU, 0, 0, 16'h0005);
		row_prog[3][6] = itype_word(OP_LW, 8, 2, 16'h0008);
		row_prog[3][7] = rtype_word(2, 0, 2, 0, FN_ADDU);
		row_prog[3][8] = rtype_word(0, 0, 0, 0, FN_JR);
		rows[3] = '{1'b0, 1'b0, 32'h2468_1357, 32'h48, 32'h2468_1357};
		// Branches, both senses, no delay slot
		row_name[4] = "branch";
		row_prog[4][0] = itype_word(OP_ADDIU, 0, 2, 16'd1);
		row_prog[4][1] = itype_word(OP_ADDIU, 0, 8, 16'd5);
		row_prog[4][2] = itype_word(OP_BEQ, 8, 0, 16'd1); // Falls through
		row_prog[4][3] = itype_word(OP_ADDIU, 2, 2, 16'd2);
		row_prog[4][4] = itype_word(OP_BNE, 8, 0, 16'd1); // Taken
		row_prog[4][5] = itype_word(OP_ADDIU, 2, 2, 16'd100);
		row_prog[4][6] = itype_word(OP_BEQ, 8, 8, 16'd1); // Taken
		row_prog[4][7] = itype_word(OP_ADDIU, 2, 2, 16'd1000);
		row_prog[4][8] = itype_word(OP_BNE, 8, 8, 16'd1); // Falls through
		row_prog[4][9] = itype_word(OP_ADDIU, 2, 2, 16'd8);
		row_prog[4][10] = 32'h0108_103F; // Undefined funct aimed at $v0, no effect
		row_prog[4][11] = rtype_word(0, 0, 0, 0, FN_JR);
		rows[4] = '{1'b0, 1'b1, 32'd1 + 32'd2 + 32'd8, 32'h2C, fill_word(6'd11)};
		// JAL, JALR and J, link difference in $v0
		base = `MIPS_RESET_VECTOR;
		row_name[5] = "jump";
		row_prog[5][0] = jtype_word(OP_JAL, base + 32'h08);
		row_prog[5][1] = itype_word(OP_ADDIU, 2, 2, 16'h0500); // Skipped
		row_prog[5][2] = rtype_word(0, 31, 2, 0, FN_ADDU);
		row_prog[5][3] = itype_word(OP_LUI, 0, 9, base[31:16]);
		row_prog[5][4] = itype_word(OP_ORI, 9, 9, 16'h0018);
		row_prog[5][5] = rtype_word(9, 0, 10, 0, FN_JALR);
		row_prog[5][6] = rtype_word(10, 2, 2, 0, FN_SUBU);
		row_prog[5][7] = jtype_word(OP_J, base + 32'h24);
		row_prog[5][8] = itype_word(OP_ADDIU, 2, 2, 16'h0300); // Skipped
		row_prog[5][9] = itype_word(OP_SW, 0, 2, 16'h0010);
		row_prog[5][10] = rtype_word(0, 0, 0, 0, FN_JR);
		x = (base + 32'h14 + 32'd4) - (base + 32'd4); // JALR link minus JAL link
		rows[5] = '{1'b0, 1'b0, x, 32'h10, x};
		// Arithmetic again under random stalls
		row_name[6] = "arith_stall";
		row_prog[6] = row_prog[0];
		rows[6] = rows[0];
		rows[6].rand_en = 1'b1;
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: core did not halt");
		$display("Some tests failed");
		$finish;
	end

	initial begin
		int seed_value;
		int errors_before;
		logic illegal_seen;
		clk = 1'b0;
		reset = 1'b1;
		clk_enable = 1'b0;
		halt_fetch = '0;
		seed_value = $urandom(55415);
		build_table();
		for (int r = 0; r < NUM_ROWS; r++) begin
			errors_before = error_count;
			illegal_seen = 1'b0;
			reset = 1'b1;
			clk_enable = 1'b0;
			for (int k = 0; k < 64; k++) begin
				imem[k] = (k < PROG_LEN) ? row_prog[r][k] : '0;
			end
			repeat (2) @(posedge clk);
			#2;
			reset = 1'b0;
			clk_enable = next_enable(rows[r].rand_en);
			forever begin // Until the jump to zero retires
				illegal_seen = illegal_seen | illegal_instr;
				@(posedge clk);
				#2;
				if (!active) break;
				clk_enable = next_enable(rows[r].rand_en);
			end
			clk_enable = 1'b1;
			for (int k = 0; k < 4; k++) begin // Halted core ignores stores and loads
				halt_fetch = k[0] ? itype_word(OP_LW, 0, 2, 16'h0010) :
					itype_word(OP_SW, 0, 2, 16'h0010);
				@(posedge clk);
				#2;
				check_active("active", 1'b0, active);
				check_active("data_write", 1'b0, data_write);
				check_active("data_read", 1'b0, data_read);
			end
			check_active("illegal_instr", rows[r].illegal, illegal_seen);
			check_word("register_v0", rows[r].v0, register_v0);
			check_word("instr_address", `MIPS_HALT_ADDR, instr_address);
			check_word("dmem", rows[r].data, dmem[rows[r].addr[7:2]]);
			if (error_count == errors_before) begin
				pass_count++;
				$display("test %s: ok", row_name[r]);
			end else begin
				$display("test %s: failed", row_name[r]);
			end
		end
		$display("%0d of %0d tests ok, %0d errors", pass_count, NUM_ROWS, error_count);
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* cpu_mips_harvard.f */
+incdir+include
src/mips_isa_pkg.sv
src/mips_ctrl_pkg.sv
src/mips_alu.sv
src/mips_regfile.sv
src/mips_decoder.sv
src/mips_pc_unit.sv
src/cpu_mips_harvard.sv
bench/cpu_mips_harvard_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f cpu_mips_harvard.f \
	--top-module cpu_mips_harvard_tb -o cpu_mips_harvard_tb
obj_dir/cpu_mips_harvard_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
